/* hdl/RecoveryManager.sv */
`timescale 1ns/1ns

module RecoveryManager (
    input  logic                             clk,
    input  logic                             arstN,
    input  logic                             reqValid,
    input  logic                             reqFromRw,
    input  RecoveryTypes::AddrPath            reqPc,
    input  RecoveryTypes::RefetchType         reqRefetch,
    input  RecoveryTypes::RecoveryCause       reqCause,
    input  RecoveryTypes::AddrPath            reqFaultAddr,
    input  RecoveryTypes::ActiveListIndexPath reqHeadPtr,
    input  RecoveryTypes::ActiveListIndexPath reqTailPtr,
    input  RecoveryTypes::AddrPath            csrTargetPc,
    input  logic                             walkBusy,
    output RecoveryTypes::PipelinePhase       phase,
    output logic                             toRecoveryPhase,
    output logic                             toCommitPhase,
    output logic                             recoveryFromRw,
    output logic                             redirectValid,
    output RecoveryTypes::AddrPath            redirectPc,
    output logic                             flushUpper,
    output logic                             recoveryBusy,
    output logic                             triggerTrap,
    output logic                             triggerReturn,
    output RecoveryTypes::AddrPath            excptPc,
    output RecoveryTypes::RecoveryCause       excptCause,
    output RecoveryTypes::AddrPath            excptFaultAddr,
    output logic                             walkStart,
    output RecoveryTypes::ActiveListIndexPath walkHead,
    output RecoveryTypes::ActiveListIndexPath walkTail
);
    import RecoveryTypes::*;

    PipelinePhase phaseReg;
    PipelinePhase phaseNext;
    logic busyLastCycle;
    logic accept;
    logic inRecover0;
    logic inRecover1;

    // captured recovery request
    logic fromRwReg;
    RefetchType refetchReg;
    AddrPath pcReg;
    RecoveryCause causeReg;
    AddrPath faultAddrReg;
    ActiveListIndexPath headReg;
    ActiveListIndexPath tailReg;

    AddrPath targetPc;

    assign inRecover0 = (phaseReg == PHASE_RECOVER_0);
    assign inRecover1 = (phaseReg == PHASE_RECOVER_1);

    // a request latched while busy was still high is dropped
    assign accept = reqValid && (phaseReg == PHASE_COMMIT) && !busyLastCycle;

    assign toCommitPhase = inRecover1 && !walkBusy;

    always_comb begin
        phaseNext = phaseReg;
        case (phaseReg)
            PHASE_COMMIT: begin
                if (accept) begin
                    phaseNext = PHASE_RECOVER_0;
                end
            end
            PHASE_RECOVER_0: begin
                phaseNext = PHASE_RECOVER_1;
            end
            PHASE_RECOVER_1: begin
                // wait for the rename rollback
                if (toCommitPhase) begin
                    phaseNext = PHASE_COMMIT;
                end
            end
            default: begin
                phaseNext = PHASE_COMMIT;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            phaseReg <= PHASE_COMMIT;
            busyLastCycle <= 1'b0;
            fromRwReg <= 1'b0;
        end else begin
            phaseReg <= phaseNext;
            busyLastCycle <= recoveryBusy;
            if (accept) begin
                fromRwReg <= reqFromRw;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            refetchReg <= reqRefetch;
            pcReg <= reqPc;
            causeReg <= reqCause;
            faultAddrReg <= reqFaultAddr;
            headReg <= reqHeadPtr;
            tailReg <= reqTailPtr;
        end
    end

    // refetch target
    always_comb begin
        case (refetchReg)
            REFETCH_NEXT_PC: targetPc = pcReg + AddrPath'(INSN_BYTE_WIDTH);
            REFETCH_TRAP: targetPc = csrTargetPc;
            REFETCH_RETURN: targetPc = csrTargetPc;
            default: targetPc = pcReg;
        endcase
    end

    assign phase = phaseReg;
    assign recoveryFromRw = fromRwReg;
    assign recoveryBusy = accept || (phaseReg != PHASE_COMMIT);

    // one-cycle broadcast in RECOVER_0
    assign toRecoveryPhase = inRecover0;
    assign flushUpper = inRecover0;
    assign redirectValid = inRecover0;
    assign redirectPc = inRecover0 ? targetPc : '0;

    // csr requests
    assign triggerTrap = inRecover0 && (refetchReg == REFETCH_TRAP);
    assign triggerReturn = inRecover0 && (refetchReg == REFETCH_RETURN);
    assign excptPc = pcReg;
    assign excptCause = causeReg;
    assign excptFaultAddr = faultAddrReg;

    // walker loads at the edge into RECOVER_1
    assign walkStart = inRecover0;
    assign walkHead = headReg;
    assign walkTail = tailReg;

endmodule : RecoveryManager

/* hdl/RecoveryRequestLatch.sv */
`timescale 1ns/1ns

module RecoveryRequestLatch (
    input  logic                             clk,
    input  logic                             arstN,
    input  logic                             commitValid,
    input  RecoveryTypes::AddrPath            commitPc,
    input  RecoveryTypes::RefetchType         commitRefetch,
    input  RecoveryTypes::RecoveryCause       commitCause,
    input  RecoveryTypes::AddrPath            commitFaultAddr,
    input  logic                             rwValid,
    input  RecoveryTypes::AddrPath            rwPc,
    input  RecoveryTypes::RefetchType         rwRefetch,
    input  RecoveryTypes::ActiveListIndexPath exceptionOpPtr,
    input  RecoveryTypes::ActiveListIndexPath activeListTailPtr,
    output logic                             reqValid,
    output logic                             reqFromRw,
    output RecoveryTypes::AddrPath            reqPc,
    output RecoveryTypes::RefetchType         reqRefetch,
    output RecoveryTypes::RecoveryCause       reqCause,
    output RecoveryTypes::AddrPath            reqFaultAddr,
    output RecoveryTypes::ActiveListIndexPath reqHeadPtr,
    output RecoveryTypes::ActiveListIndexPath reqTailPtr
);
    import RecoveryTypes::*;

    RefetchType selRefetch;
    ActiveListIndexPath headPtr;

    // commit stage is older, so its report wins
    assign selRefetch = commitValid ? commitRefetch : rwRefetch;

    // flush starts at the faulting op only when it is refetched or trapped
    assign headPtr = (selRefetch inside {REFETCH_THIS_PC, REFETCH_TRAP}) ?
        exceptionOpPtr : exceptionOpPtr + 1'b1;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            reqValid <= 1'b0;
            reqFromRw <= 1'b0;
        end else begin
            reqValid <= commitValid || rwValid;
            reqFromRw <= rwValid && !commitValid;
        end
    end

    // request payload
    always_ff @(posedge clk) begin
        reqPc <= commitValid ? commitPc : rwPc;
        reqRefetch <= selRefetch;
        // only the commit stage reports traps
        reqCause <= commitCause;
        reqFaultAddr <= commitFaultAddr;
        reqHeadPtr <= headPtr;
        reqTailPtr <= activeListTailPtr;
    end

endmodule : RecoveryRequestLatch

/* hdl/RecoveryTop.sv */
`timescale 1ns/1ns

module RecoveryTop (
    input  logic                             clk,
    input  logic                             arstN,
    input  logic                             commitValid,
    input  RecoveryTypes::AddrPath            commitPc,
    input  RecoveryTypes::RefetchType         commitRefetch,
    input  RecoveryTypes::RecoveryCause       commitCause,
    input  RecoveryTypes::AddrPath            commitFaultAddr,
    input  logic                             rwValid,
    input  RecoveryTypes::AddrPath            rwPc,
    input  RecoveryTypes::RefetchType         rwRefetch,
    input  RecoveryTypes::ActiveListIndexPath exceptionOpPtr,
    input  RecoveryTypes::ActiveListIndexPath activeListTailPtr,
    input  logic                             trapVectorWe,
    input  RecoveryTypes::AddrPath            trapVectorData,
    output RecoveryTypes::PipelinePhase       phase,
    output logic                             toRecoveryPhase,
    output logic                             toCommitPhase,
    output logic                             recoveryFromRw,
    output logic                             redirectValid,
    output RecoveryTypes::AddrPath            redirectPc,
    output logic                             flushUpper,
    output logic                             recoveryBusy,
    output logic                             rollbackValid,
    output RecoveryTypes::ActiveListIndexPath rollbackPtr,
    output RecoveryTypes::AddrPath            savedEpc,
    output RecoveryTypes::RecoveryCause       savedCause,
    output RecoveryTypes::AddrPath            savedFaultAddr
);
    import RecoveryTypes::*;

    // latch to manager
    logic reqValid;
    logic reqFromRw;
    AddrPath reqPc;
    RefetchType reqRefetch;
    RecoveryCause reqCause;
    AddrPath reqFaultAddr;
    ActiveListIndexPath reqHeadPtr;
    ActiveListIndexPath reqTailPtr;

    // manager to csr unit
    logic triggerTrap;
    logic triggerReturn;
    AddrPath excptPc;
    RecoveryCause excptCause;
    AddrPath excptFaultAddr;
    AddrPath csrTargetPc;

    // manager to walker
    logic walkStart;
    ActiveListIndexPath walkHead;
    ActiveListIndexPath walkTail;
    logic walkBusy;

    RecoveryRequestLatch i_RecoveryRequestLatch (
        .clk(clk),
        .arstN(arstN),
        .commitValid(commitValid),
        .commitPc(commitPc),
        .commitRefetch(commitRefetch),
        .commitCause(commitCause),
        .commitFaultAddr(commitFaultAddr),
        .rwValid(rwValid),
        .rwPc(rwPc),
        .rwRefetch(rwRefetch),
        .exceptionOpPtr(exceptionOpPtr),
        .activeListTailPtr(activeListTailPtr),
        .reqValid(reqValid),
        .reqFromRw(reqFromRw),
        .reqPc(reqPc),
        .reqRefetch(reqRefetch),
        .reqCause(reqCause),
        .reqFaultAddr(reqFaultAddr),
        .reqHeadPtr(reqHeadPtr),
        .reqTailPtr(reqTailPtr)
    );

    RecoveryManager i_RecoveryManager (
        .clk(clk),
        .arstN(arstN),
        .reqValid(reqValid),
        .reqFromRw(reqFromRw),
        .reqPc(reqPc),
        .reqRefetch(reqRefetch),
        .reqCause(reqCause),
        .reqFaultAddr(reqFaultAddr),
        .reqHeadPtr(reqHeadPtr),
        .reqTailPtr(reqTailPtr),
        .csrTargetPc(csrTargetPc),
        .walkBusy(walkBusy),
        .phase(phase),
        .toRecoveryPhase(toRecoveryPhase),
        .toCommitPhase(toCommitPhase),
        .recoveryFromRw(recoveryFromRw),
        .redirectValid(redirectValid),
        .redirectPc(redirectPc),
        .flushUpper(flushUpper),
        .recoveryBusy(recoveryBusy),
        .triggerTrap(triggerTrap),
        .triggerReturn(triggerReturn),
        .excptPc(excptPc),
        .excptCause(excptCause),
        .excptFaultAddr(excptFaultAddr),
        .walkStart(walkStart),
        .walkHead(walkHead),
        .walkTail(walkTail)
    );

    TrapCsrUnit i_TrapCsrUnit (
        .clk(clk),
        .arstN(arstN),
        .trapVectorWe(trapVectorWe),
        .trapVectorData(trapVectorData),
        .triggerTrap(triggerTrap),
        .triggerReturn(triggerReturn),
        .excptPc(excptPc),
        .excptCause(excptCause),
        .excptFaultAddr(excptFaultAddr),
        .csrTargetPc(csrTargetPc),
        .savedEpc(savedEpc),
        .savedCause(savedCause),
        .savedFaultAddr(savedFaultAddr)
    );

    RenameRollbackWalker i_RenameRollbackWalker (
        .clk(clk),
        .arstN(arstN),
        .walkStart(walkStart),
        .walkHead(walkHead),
        .walkTail(walkTail),
        .walkBusy(walkBusy),
        .rollbackValid(rollbackValid),
        .rollbackPtr(rollbackPtr)
    );

endmodule : RecoveryTop

/* hdl/RecoveryTypes.sv */
package RecoveryTypes;

    // address sizing
    localparam int ADDR_WIDTH = 32;
    localparam int INSN_BYTE_WIDTH = 4;

    // active list sizing
    localparam int ACTIVE_LIST_ENTRY_NUM = 16;
    localparam int ACTIVE_LIST_INDEX_WIDTH = $clog2(ACTIVE_LIST_ENTRY_NUM);

    // trap cause code width
    localparam int RECOVERY_CAUSE_WIDTH = 4;

    typedef logic [ADDR_WIDTH-1:0] AddrPath;

    typedef logic [ACTIVE_LIST_INDEX_WIDTH-1:0] ActiveListIndexPath;

    typedef logic [RECOVERY_CAUSE_WIDTH-1:0] RecoveryCause;

    // recovery phase of the pipeline
    typedef enum logic [1:0] {
        PHASE_COMMIT    = 2'd0,
        PHASE_RECOVER_0 = 2'd1,
        PHASE_RECOVER_1 = 2'd2
    } PipelinePhase;

    // where fetch resumes after recovery
    typedef enum logic [2:0] {
        // faulting pc itself
        REFETCH_THIS_PC       = 3'd0,
        // faulting pc plus one instruction
        REFETCH_NEXT_PC       = 3'd1,
        // reported pc is already the target
        REFETCH_BRANCH_TARGET = 3'd2,
        // trap vector from the csr unit
        REFETCH_TRAP          = 3'd3,
        // saved exception pc from the csr unit
        REFETCH_RETURN        = 3'd4
    } RefetchType;

endpackage : RecoveryTypes

/* hdl/RenameRollbackWalker.sv */
`timescale 1ns/1ns

module RenameRollbackWalker (
    input  logic                             clk,
    input  logic                             arstN,
    input  logic                             walkStart,
    input  RecoveryTypes::ActiveListIndexPath walkHead,
    input  RecoveryTypes::ActiveListIndexPath walkTail,
    output logic                             walkBusy,
    output logic                             rollbackValid,
    output RecoveryTypes::ActiveListIndexPath rollbackPtr
);
    import RecoveryTypes::*;

    // entries still to restore
    ActiveListIndexPath remaining;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            remaining <= '0;
        end else if (walkStart) begin
            // range length wraps with the index width
            remaining <= walkTail - walkHead;
        end else if (remaining != '0) begin
            remaining <= remaining - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (walkStart) begin
            rollbackPtr <= walkHead;
        end else if (remaining != '0) begin
            rollbackPtr <= rollbackPtr + 1'b1;
        end
    end

    // an empty range is done right after loading
    assign walkBusy = (remaining != '0);
    assign rollbackValid = walkBusy;

endmodule : RenameRollbackWalker

/* hdl/TrapCsrUnit.sv */
`timescale 1ns/1ns

module TrapCsrUnit (
    input  logic                       clk,
    input  logic                       arstN,
    input  logic                       trapVectorWe,
    input  RecoveryTypes::AddrPath      trapVectorData,
    input  logic                       triggerTrap,
    input  logic                       triggerReturn,
    input  RecoveryTypes::AddrPath      excptPc,
    input  RecoveryTypes::RecoveryCause excptCause,
    input  RecoveryTypes::AddrPath      excptFaultAddr,
    output RecoveryTypes::AddrPath      csrTargetPc,
    output RecoveryTypes::AddrPath      savedEpc,
    output RecoveryTypes::RecoveryCause savedCause,
    output RecoveryTypes::AddrPath      savedFaultAddr
);
    import RecoveryTypes::*;

    AddrPath trapVector;

    // trap vector, only written from outside
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            trapVector <= '0;
        end else if (trapVectorWe) begin
            trapVector <= trapVectorData;
        end
    end

    // exception state recorded on trap entry
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            savedEpc <= '0;
            savedCause <= '0;
            savedFaultAddr <= '0;
        end else if (triggerTrap) begin
            savedEpc <= excptPc;
            savedCause <= excptCause;
            savedFaultAddr <= excptFaultAddr;
        end
    end

    // return goes back to the saved pc, everything else to the vector
    assign csrTargetPc = triggerReturn ? savedEpc : trapVector;

endmodule : TrapCsrUnit

/* src.f */
+incdir+testbench
hdl/RecoveryTypes.sv
hdl/RecoveryRequestLatch.sv
hdl/RecoveryManager.sv
hdl/TrapCsrUnit.sv
hdl/RenameRollbackWalker.sv
hdl/RecoveryTop.sv
testbench/RecoveryTb.sv

/* testbench/RecoveryTbCases.svh */
`ifndef RECOVERY_TB_CASES_SVH
`define RECOVERY_TB_CASES_SVH

localparam int DIRECTED_NUM = 10;

// fields in CaseRow order
// commit valid, pc, refetch, cause, fault address
// rw valid, pc, refetch, op ptr, tail ptr, trap vector we and data, busy poke
// expected redirect pc, from rw, flush head, flush length, epc, cause, fault address
function automatic CaseRow directedCase(input int idx);
    CaseRow row;
    case (idx)
        0: row = {1'b1, 32'h0000_1000, REFETCH_THIS_PC, 4'h2, 32'h0,
            1'b0, 32'h0, REFETCH_THIS_PC, 4'd3, 4'd7, 1'b0, 32'h0, 1'b0,
            32'h0000_1000, 1'b0, 4'd3, 4'd4, 32'h0, 4'h0, 32'h0};
        1: row = {1'b0, 32'h0, REFETCH_THIS_PC, 4'h0, 32'h0,
            1'b1, 32'h0000_2000, REFETCH_NEXT_PC, 4'd5, 4'd9, 1'b0, 32'h0, 1'b0,
            32'h0000_2004, 1'b1, 4'd6, 4'd3, 32'h0, 4'h0, 32'h0};
        // range wraps past entry 15
        2: row = {1'b1, 32'h0000_3400, REFETCH_BRANCH_TARGET, 4'h0, 32'h0,
            1'b0, 32'h0, REFETCH_THIS_PC, 4'd14, 4'd2, 1'b0, 32'h0, 1'b0,
            32'h0000_3400, 1'b0, 4'd15, 4'd3, 32'h0, 4'h0, 32'h0};
        3: row = {1'b1, 32'h0000_4010, REFETCH_TRAP, 4'hB, 32'hDEAD_BEE0,
            1'b0, 32'h0, REFETCH_THIS_PC, 4'd4, 4'd4, 1'b1, 32'h8000_0100, 1'b0,
            32'h8000_0100, 1'b0, 4'd4, 4'd0, 32'h0000_4010, 4'hB, 32'hDEAD_BEE0};
        // return to the pc saved by the trap above
        4: row = {1'b1, 32'h0000_5000, REFETCH_RETURN, 4'h0, 32'h0,
            1'b0, 32'h0, REFETCH_THIS_PC, 4'd2, 4'd2, 1'b0, 32'h0, 1'b0,
            32'h0000_4010, 1'b0, 4'd3, 4'd15, 32'h0000_4010, 4'hB, 32'hDEAD_BEE0};
        5: row = {1'b1, 32'h0000_6000, REFETCH_NEXT_PC, 4'h1, 32'h0,
            1'b1, 32'h0000_7000, REFETCH_THIS_PC, 4'd8, 4'd12, 1'b0, 32'h0, 1'b0,
            32'h0000_6004, 1'b0, 4'd9, 4'd3, 32'h0000_4010, 4'hB, 32'hDEAD_BEE0};
        6: row = {1'b1, 32'h0000_6100, REFETCH_THIS_PC, 4'h1, 32'h0,
            1'b1, 32'h0000_7100, REFETCH_BRANCH_TARGET, 4'd10, 4'd10, 1'b0, 32'h0, 1'b0,
            32'h0000_6100, 1'b0, 4'd10, 4'd0, 32'h0000_4010, 4'hB, 32'hDEAD_BEE0};
        7: row = {1'b1, 32'h0000_9000, REFETCH_THIS_PC, 4'h0, 32'h0,
            1'b0, 32'h0, REFETCH_THIS_PC, 4'd0, 4'd5, 1'b0, 32'h0, 1'b1,
            32'h0000_9000, 1'b0, 4'd0, 4'd5, 32'h0000_4010, 4'hB, 32'hDEAD_BEE0};
        8: row = {1'b0, 32'h0, REFETCH_THIS_PC, 4'h0, 32'h0,
            1'b1, 32'h0000_A000, REFETCH_BRANCH_TARGET, 4'd7, 4'd8, 1'b0, 32'h0, 1'b1,
            32'h0000_A000, 1'b1, 4'd8, 4'd0, 32'h0000_4010, 4'hB, 32'hDEAD_BEE0};
        9: row = {1'b1, 32'h0000_B00C, REFETCH_TRAP, 4'h3, 32'h1234_5678,
            1'b0, 32'h0, REFETCH_THIS_PC, 4'd1, 4'd9, 1'b1, 32'h0000_0200, 1'b0,
            32'h0000_0200, 1'b0, 4'd1, 4'd8, 32'h0000_B00C, 4'h3, 32'h1234_5678};
        default: row = '0;
    endcase
    return row;
endfunction

`endif

/* testbench/RecoveryTb.sv */
`timescale 1ns/1ns

module RecoveryTb;
    import RecoveryTypes::*;

    typedef struct packed {
        logic useCommit;
        AddrPath commitPc;
        RefetchType commitRefetch;
        RecoveryCause cause;
        AddrPath faultAddr;
        logic useRw;
        AddrPath rwPc;
        RefetchType rwRefetch;
        ActiveListIndexPath opPtr;
        ActiveListIndexPath tailPtr;
        logic tvecWe;
        AddrPath tvecData;
        logic poke;
        AddrPath expRedirect;
        logic expFromRw;
        ActiveListIndexPath expHead;
        ActiveListIndexPath expLen;
        AddrPath expEpc;
        RecoveryCause expCause;
        AddrPath expFault;
    } CaseRow;

    `include "RecoveryTbCases.svh"

    localparam int RANDOM_NUM = 8;
    localparam int ROW_NUM = DIRECTED_NUM + RANDOM_NUM;
    localparam int WATCHDOG_CYCLES = ROW_NUM * 40 + 100;
    localparam int WAIT_LIMIT = 40;
    localparam logic [31:0] RANDOM_SEED = 32'he76e_e532;

    logic clk;
    logic arstN;
    logic commitValid;
    AddrPath commitPc;
    RefetchType commitRefetch;
    RecoveryCause commitCause;
    AddrPath commitFaultAddr;
    logic rwValid;
    AddrPath rwPc;
    RefetchType rwRefetch;
    ActiveListIndexPath exceptionOpPtr;
    ActiveListIndexPath activeListTailPtr;
    logic trapVectorWe;
    AddrPath trapVectorData;
    PipelinePhase phase;
    logic toRecoveryPhase;
    logic toCommitPhase;
    logic recoveryFromRw;
    logic redirectValid;
    AddrPath redirectPc;
    logic flushUpper;
    logic recoveryBusy;
    logic rollbackValid;
    ActiveListIndexPath rollbackPtr;
    AddrPath savedEpc;
    RecoveryCause savedCause;
    AddrPath savedFaultAddr;

    CaseRow rows [ROW_NUM];
    int errorCount;
    int checkCount;

    RecoveryTop i_RecoveryTop (
        .clk(clk),
        .arstN(arstN),
        .commitValid(commitValid),
        .commitPc(commitPc),
        .commitRefetch(commitRefetch),
        .commitCause(commitCause),
        .commitFaultAddr(commitFaultAddr),
        .rwValid(rwValid),
        .rwPc(rwPc),
        .rwRefetch(rwRefetch),
        .exceptionOpPtr(exceptionOpPtr),
        .activeListTailPtr(activeListTailPtr),
        .trapVectorWe(trapVectorWe),
        .trapVectorData(trapVectorData),
        .phase(phase),
        .toRecoveryPhase(toRecoveryPhase),
        .toCommitPhase(toCommitPhase),
        .recoveryFromRw(recoveryFromRw),
        .redirectValid(redirectValid),
        .redirectPc(redirectPc),
        .flushUpper(flushUpper),
        .recoveryBusy(recoveryBusy),
        .rollbackValid(rollbackValid),
        .rollbackPtr(rollbackPtr),
        .savedEpc(savedEpc),
        .savedCause(savedCause),
        .savedFaultAddr(savedFaultAddr)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic checkValue(input string what, input logic [31:0] actual,
        input logic [31:0] expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("ERR %0t ns: %s mismatch, got 0x%0h, expected 0x%0h",
                $time, what, actual, expected);
        end
    endtask

    // expected results straight from the recovery rules
    task automatic predictRow(
        inout CaseRow row,
        inout AddrPath tvec,
        inout AddrPath epc,
        inout RecoveryCause cause,
        inout AddrPath fault
    );
        RefetchType refetch;
        AddrPath pc;
        refetch = row.useCommit ? row.commitRefetch : row.rwRefetch;
        pc = row.useCommit ? row.commitPc : row.rwPc;
        if (row.tvecWe) begin
            tvec = row.tvecData;
        end
        if (refetch == REFETCH_THIS_PC || refetch == REFETCH_TRAP) begin
            row.expHead = row.opPtr;
        end else begin
            row.expHead = row.opPtr + 4'd1;
        end
        row.expLen = row.tailPtr - row.expHead;
        case (refetch)
            REFETCH_NEXT_PC: row.expRedirect = pc + 32'd4;
            REFETCH_TRAP: row.expRedirect = tvec;
            REFETCH_RETURN: row.expRedirect = epc;
            default: row.expRedirect = pc;
        endcase
        row.expFromRw = !row.useCommit;
        if (refetch == REFETCH_TRAP) begin
            epc = pc;
            cause = row.cause;
            fault = row.faultAddr;
        end
        row.expEpc = epc;
        row.expCause = cause;
        row.expFault = fault;
    endtask

    task automatic makeRandomCases();
        AddrPath tvec;
        AddrPath epc;
        RecoveryCause cause;
        AddrPath fault;
        CaseRow row;
        logic [31:0] rnd;
        int i;
        tvec = '0;
        epc = '0;
        cause = '0;
        fault = '0;
        for (i = 0; i < ROW_NUM; i++) begin
            if (i < DIRECTED_NUM) begin
                // follow csr state through the directed rows
                row = directedCase(i);
                if (row.tvecWe) begin
                    tvec = row.tvecData;
                end
                epc = row.expEpc;
                cause = row.expCause;
                fault = row.expFault;
            end else begin
                row = '0;
                rnd = $urandom;
                row.useCommit = rnd[0];
                row.useRw = rnd[1] || !rnd[0];
                row.tvecWe = rnd[2];
                row.poke = (rnd[4:3] == 2'b00);
                row.opPtr = rnd[11:8];
                row.tailPtr = rnd[15:12];
                row.cause = rnd[19:16];
                row.rwRefetch = RefetchType'(3'(rnd[23:20] % 4'd3));
                row.commitRefetch = RefetchType'(3'(rnd[31:24] % 8'd5));
                row.commitPc = $urandom & 32'hFFFF_FFFC;
                row.rwPc = $urandom & 32'hFFFF_FFFC;
                row.faultAddr = $urandom;
                row.tvecData = $urandom & 32'hFFFF_FFFC;
                predictRow(row, tvec, epc, cause, fault);
            end
            rows[i] = row;
        end
    endtask

    task automatic driveIdle();
        commitValid = 1'b0;
        rwValid = 1'b0;
        trapVectorWe = 1'b0;
    endtask

    task automatic driveRequest(input CaseRow row);
        commitValid = row.useCommit;
        commitPc = row.commitPc;
        commitRefetch = row.commitRefetch;
        commitCause = row.cause;
        commitFaultAddr = row.faultAddr;
        rwValid = row.useRw;
        rwPc = row.rwPc;
        rwRefetch = row.rwRefetch;
        exceptionOpPtr = row.opPtr;
        activeListTailPtr = row.tailPtr;
    endtask

    // a trap from both stages that must be dropped
    task automatic driveSpurious();
        commitValid = 1'b1;
        commitPc = 32'hFFFF_0000;
        commitRefetch = REFETCH_TRAP;
        commitCause = 4'hF;
        commitFaultAddr = 32'hFFFF_FFFC;
        rwValid = 1'b1;
        exceptionOpPtr = 4'd0;
        activeListTailPtr = 4'd15;
    endtask

    task automatic checkResetState();
        checkValue("phase after reset", 32'(phase), 32'(PHASE_COMMIT));
        checkValue("toRecoveryPhase after reset", 32'(toRecoveryPhase), 32'd0);
        checkValue("toCommitPhase after reset", 32'(toCommitPhase), 32'd0);
        checkValue("redirectValid after reset", 32'(redirectValid), 32'd0);
        checkValue("flushUpper after reset", 32'(flushUpper), 32'd0);
        checkValue("rollbackValid after reset", 32'(rollbackValid), 32'd0);
        checkValue("recoveryBusy after reset", 32'(recoveryBusy), 32'd0);
        checkValue("savedEpc after reset", savedEpc, 32'd0);
        checkValue("savedCause after reset", 32'(savedCause), 32'd0);
        checkValue("savedFaultAddr after reset", savedFaultAddr, 32'd0);
    endtask

    task automatic applyCase(input CaseRow row);
        int waited;
        int walked;
        ActiveListIndexPath expPtr;
        @(negedge clk);
        waited = 0;
        while (recoveryBusy && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (recoveryBusy) begin
            errorCount++;
            $display("recoveryBusy stayed high, no request could be sent");
            return;
        end
        if (row.tvecWe) begin
            trapVectorWe = 1'b1;
            trapVectorData = row.tvecData;
            @(negedge clk);
            trapVectorWe = 1'b0;
        end
        driveRequest(row);
        waited = 0;
        do begin
            @(negedge clk);
            driveIdle();
            waited++;
        end while (!toRecoveryPhase && waited < WAIT_LIMIT);
        if (!toRecoveryPhase) begin
            errorCount++;
            $display("request was never followed by a recovery phase");
            return;
        end
        // latched at the first edge, RECOVER_0 after the second
        checkValue("cycles until redirect", 32'(waited), 32'd2);
        checkValue("phase at redirect", 32'(phase), 32'(PHASE_RECOVER_0));
        checkValue("redirectValid", 32'(redirectValid), 32'd1);
        checkValue("flushUpper", 32'(flushUpper), 32'd1);
        checkValue("recoveryBusy at redirect", 32'(recoveryBusy), 32'd1);
        checkValue("redirectPc", redirectPc, row.expRedirect);
        checkValue("recoveryFromRw", 32'(recoveryFromRw), 32'(row.expFromRw));
        waited = 0;
        walked = 0;
        expPtr = row.expHead;
        do begin
            @(negedge clk);
            driveIdle();
            waited++;
            checkValue("phase during walk", 32'(phase), 32'(PHASE_RECOVER_1));
            if (!toCommitPhase) begin
                // pulses must come back to back
                checkValue("rollbackValid during walk", 32'(rollbackValid), 32'd1);
                checkValue("rollbackPtr", 32'(rollbackPtr), 32'(expPtr));
                expPtr = expPtr + 4'd1;
                walked++;
            end
        end while (!toCommitPhase && waited < WAIT_LIMIT);
        if (!toCommitPhase) begin
            errorCount++;
            $display("rollback walk did not end with a return to commit");
            return;
        end
        checkValue("rollbackValid at toCommitPhase", 32'(rollbackValid), 32'd0);
        checkValue("walk length", 32'(walked), 32'(row.expLen));
        // busy is still high here, so this request lands on the edge back to commit
        if (row.poke) begin
            driveSpurious();
        end
        @(negedge clk);
        driveIdle();
        checkValue("phase after recovery", 32'(phase), 32'(PHASE_COMMIT));
        checkValue("recoveryBusy after recovery", 32'(recoveryBusy), 32'd0);
        checkValue("savedEpc", savedEpc, row.expEpc);
        checkValue("savedCause", 32'(savedCause), 32'(row.expCause));
        checkValue("savedFaultAddr", savedFaultAddr, row.expFault);
        if (row.poke) begin
            repeat (6) begin
                @(negedge clk);
                checkValue("toRecoveryPhase after dropped request", 32'(toRecoveryPhase),
                    32'd0);
            end
        end
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not complete",
            WATCHDOG_CYCLES);
        $display("Test failures found");
        $finish;
    end

    initial begin
        int i;
        errorCount = 0;
        checkCount = 0;
        arstN = 1'b0;
        trapVectorWe = 1'b0;
        trapVectorData = '0;
        commitPc = '0;
        commitRefetch = REFETCH_THIS_PC;
        commitCause = '0;
        commitFaultAddr = '0;
        rwPc = '0;
        rwRefetch = REFETCH_THIS_PC;
        exceptionOpPtr = '0;
        activeListTailPtr = '0;
        driveIdle();
        void'($urandom(RANDOM_SEED));
        makeRandomCases();
        repeat (8) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
        @(negedge clk);
        checkResetState();
        for (i = 0; i < ROW_NUM; i++) begin
            applyCase(rows[i]);
        end
        $display("checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule : RecoveryTb
